/* rtl/fetch_pkg.sv */
// shared widths, defaults and packed types for the fetch alignment and pre-decode frontend
package fetch_pkg;

    localparam int FETCH_WIDTH    = 4;   // instruction slots per cycle
    localparam int LINE_HALFWORDS = 4;   // half-words in one fetch line
    localparam int FQ_DEPTH       = 16;  // fetch queue entries, power of two
    localparam int XLEN           = 64;  // address width

    typedef logic [XLEN-1:0] addr_t;

    typedef struct packed {
        addr_t                               pc;
        logic [LINE_HALFWORDS-1:0][15:0]     data;
        logic [$clog2(LINE_HALFWORDS+1)-1:0] size;        // half-words used
        logic                                pred_taken;
        logic [6:0]                          pred_tgt;    // target bits 7:1
    } line_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } full_fmt_t;

    typedef struct packed {
        logic [15:0] upper;    // zero for compressed slots
        logic [2:0]  funct3;
        logic        b12;
        logic [4:0]  rd_rs1;
        logic [4:0]  rs2;
        logic [1:0]  op;
    } comp_fmt_t;

    typedef union packed {
        full_fmt_t full;
        comp_fmt_t comp;
    } inst_word_u;

    typedef struct packed {
        logic       valid;
        addr_t      pc;
        inst_word_u ir;
        logic       wide;        // 32-bit encoding
        logic       last;        // ends the line
        logic       pred_taken;  // line prediction, set on the last slot only
        logic [6:0] pred_tgt;
    } slot_t;

    typedef struct packed {
        logic  branch;
        logic  jal;
        logic  jalr;
        logic  call;
        logic  ret;
        addr_t target;
    } pd_info_t;

    typedef struct packed {
        logic       valid;
        addr_t      pc;
        inst_word_u ir;
        logic       branch;
        logic       jal;
        logic       jalr;
        logic       call;
        logic       ret;
    } fet_bundle_t;

    // pat 2'b10 for a false taken prediction, 2'b01 for a wrong or missing target
    typedef struct packed {
        logic       valid;
        addr_t      pc;
        addr_t      npc;
        logic [1:0] pat;
    } redir_t;

endpackage

/* rtl/line_splitter.sv */
// line buffer that cuts the held fetch line into 16-bit and 32-bit instruction slots
module line_splitter #(
    parameter int fetch_width    = 4,
    parameter int line_halfwords = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              flush,
    input  fetch_pkg::line_t                  line_in,
    input  logic                              line_valid,
    output logic                              line_ready,
    input  logic [$clog2(fetch_width+1)-1:0]  accept_num,
    input  logic                              consume_all,
    output fetch_pkg::slot_t [fetch_width-1:0] slots
);
    import fetch_pkg::*;

    localparam int pw = $clog2(line_halfwords + 2 * fetch_width + 1); // position width

    line_t                        cur_line;               // buffered line
    logic                         cur_valid;
    logic [pw-1:0]                cursor;                 // first unconsumed half-word
    logic [pw-1:0]                pos [fetch_width+1];    // start of each slot
    logic [fetch_width-1:0][15:0] lo_hw, hi_hw;
    logic [fetch_width-1:0]       wide;

    // positions past the line read as zero
    function automatic logic [15:0] half_at(input logic [line_halfwords-1:0][15:0] data,
                                            input logic [pw-1:0] p);
        half_at = 16'h0;
        if (p < pw'(line_halfwords)) half_at = data[p];
    endfunction

    always_comb begin
        pos[0] = cursor;
        for (int i = 0; i < fetch_width; i++) begin
            lo_hw[i]  = half_at(cur_line.data, pos[i]);
            hi_hw[i]  = half_at(cur_line.data, pos[i] + pw'(1));
            wide[i]   = &lo_hw[i][1:0];                       // 11 starts a 32-bit word
            pos[i+1]  = pos[i] + (wide[i] ? pw'(2) : pw'(1));
            slots[i].valid      = cur_valid && pos[i+1] <= pw'(cur_line.size);
            slots[i].pc         = cur_line.pc + addr_t'({pos[i], 1'b0});
            slots[i].ir         = wide[i] ? {hi_hw[i], lo_hw[i]} : {16'h0, lo_hw[i]};
            slots[i].wide       = wide[i];
            slots[i].last       = slots[i].valid && pos[i+1] == pw'(cur_line.size);
            slots[i].pred_taken = slots[i].last && cur_line.pred_taken;
            slots[i].pred_tgt   = slots[i].last ? cur_line.pred_tgt : 7'h0;
        end
    end

    assign line_ready = ~cur_valid;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            cur_valid <= 1'b0;
            cursor    <= '0;
        end else if (line_valid && line_ready) begin
            cur_valid <= 1'b1;
            cursor    <= '0;
        end else if (cur_valid) begin
            if (consume_all || pos[accept_num] >= pw'(cur_line.size)) begin
                cur_valid <= 1'b0;                             // line fully handed over
                cursor    <= '0;
            end else begin
                cursor <= pos[accept_num];                     // partial accept
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_valid && line_ready) cur_line <= line_in;
    end

endmodule

/* rtl/predecoder.sv */
// pre-decode of each instruction slot into control-flow classes and a jump target
module predecoder #(
    parameter int fetch_width = 4
) (
    input  fetch_pkg::slot_t    [fetch_width-1:0] slots,
    output fetch_pkg::pd_info_t [fetch_width-1:0] pd
);
    import fetch_pkg::*;

    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_jal    = 7'b1101111;

    function automatic logic is_link(input logic [4:0] r);
        is_link = r == 5'd1 || r == 5'd5;                      // ra or t0
    endfunction

    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            // 32-bit formats, compressed words never match these opcodes
            pd[i].branch = slots[i].ir.full.opcode == op_branch;
            pd[i].jalr   = slots[i].ir.full.opcode == op_jalr;
            pd[i].jal    = slots[i].ir.full.opcode == op_jal;
            pd[i].call   = (pd[i].jal || pd[i].jalr) && is_link(slots[i].ir.full.rd);
            // same link register on both sides counts as call only
            pd[i].ret    = pd[i].jalr && is_link(slots[i].ir.full.rs1)
                        && slots[i].ir.full.rs1 != slots[i].ir.full.rd;
            pd[i].target = slots[i].pc + (slots[i].wide ? addr_t'(4) : addr_t'(2));

            if (pd[i].branch) begin
                pd[i].target = slots[i].pc + {{52{slots[i].ir[31]}}, slots[i].ir[7],
                    slots[i].ir[30:25], slots[i].ir[11:8], 1'b0};
            end
            if (pd[i].jal) begin
                pd[i].target = slots[i].pc + {{44{slots[i].ir[31]}}, slots[i].ir[19:12],
                    slots[i].ir[20], slots[i].ir[30:21], 1'b0};
            end

            // C.J
            if (slots[i].ir.comp.op == 2'b01 && slots[i].ir.comp.funct3 == 3'b101) begin
                pd[i].jal    = 1'b1;
                pd[i].target = slots[i].pc + {{53{slots[i].ir[12]}}, slots[i].ir[8],
                    slots[i].ir[10:9], slots[i].ir[6], slots[i].ir[7], slots[i].ir[2],
                    slots[i].ir[11], slots[i].ir[5:3], 1'b0};
            end
            // C.BEQZ and C.BNEZ
            if (slots[i].ir.comp.op == 2'b01 && slots[i].ir.comp.funct3[2:1] == 2'b11) begin
                pd[i].branch = 1'b1;
                pd[i].target = slots[i].pc + {{56{slots[i].ir[12]}}, slots[i].ir[6:5],
                    slots[i].ir[2], slots[i].ir[11:10], slots[i].ir[4:3], 1'b0};
            end
            // C.JR and C.JALR, target left at fall-through
            if (slots[i].ir.comp.op == 2'b10 && slots[i].ir.comp.funct3 == 3'b100
                && slots[i].ir.comp.rs2 == 5'd0) begin
                pd[i].jalr = 1'b1;
                if (slots[i].ir.comp.b12) pd[i].call = 1'b1;  // C.JALR links x1
                pd[i].ret  = (slots[i].ir.comp.rd_rs1 == 5'd1 && !slots[i].ir.comp.b12)
                          || slots[i].ir.comp.rd_rs1 == 5'd5;
            end
        end
    end

endmodule

/* rtl/redirect_ctrl.sv */
// accepts slots into the fetch queue in order and raises a redirect on a wrong line prediction
module redirect_ctrl #(
    parameter int fetch_width = 4,
    parameter int fq_depth    = 16
) (
    input  fetch_pkg::slot_t      [fetch_width-1:0] slots,
    input  fetch_pkg::pd_info_t   [fetch_width-1:0] pd,
    input  logic [$clog2(fq_depth+1)-1:0]           fq_free,
    output logic [$clog2(fetch_width+1)-1:0]        accept_num,
    output logic                                    consume_all,
    output fetch_pkg::fet_bundle_t [fetch_width-1:0] enq,
    output fetch_pkg::redir_t                       redir
);
    import fetch_pkg::*;

    localparam int cw = $clog2(fq_depth + 1);

    logic                   done;   // no more slots this cycle
    logic [fetch_width-1:0] flow;   // branch, jal or jalr
    logic [fetch_width-1:0] false_taken, bad_target;

    always_comb begin
        accept_num = '0;
        done       = 1'b0;
        redir      = '0;
        for (int i = 0; i < fetch_width; i++) begin
            flow[i]        = pd[i].branch || pd[i].jal || pd[i].jalr;
            false_taken[i] = slots[i].pred_taken && !flow[i];
            bad_target[i]  = (pd[i].jal && !slots[i].pred_taken)
                          || ((pd[i].jal || (pd[i].branch && slots[i].pred_taken))
                              && pd[i].target[7:1] != slots[i].pred_tgt);
            enq[i].valid  = 1'b0;
            enq[i].pc     = slots[i].pc;
            enq[i].ir     = slots[i].ir;
            enq[i].branch = pd[i].branch;
            enq[i].jal    = pd[i].jal;
            enq[i].jalr   = pd[i].jalr;
            enq[i].call   = pd[i].call;
            enq[i].ret    = pd[i].ret;
            if (!done && slots[i].valid && cw'(accept_num) < fq_free) begin
                accept_num   = accept_num + 1'b1;
                enq[i].valid = 1'b1;               // redirecting slot is still enqueued
                if (slots[i].last && (false_taken[i] || bad_target[i])) begin
                    redir.valid = 1'b1;
                    redir.pat   = false_taken[i] ? 2'b10 : 2'b01;
                    redir.pc    = slots[i].pc + (slots[i].wide ? addr_t'(2) : addr_t'(0));
                    redir.npc   = pd[i].target;    // fall-through when not a flow change
                    done        = 1'b1;
                end
            end else begin
                done = 1'b1;                       // queue full or end of valid prefix
            end
        end
        consume_all = redir.valid;
    end

endmodule

/* rtl/fetch_queue.sv */
// circular fetch queue with fetch_width write ports at the tail and read ports at the front
module fetch_queue #(
    parameter int fetch_width = 4,
    parameter int fq_depth    = 16
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    flush,
    input  logic [$clog2(fetch_width+1)-1:0]        accept_num,
    input  fetch_pkg::fet_bundle_t [fetch_width-1:0] enq,
    input  logic [fetch_width-1:0]                  fetch,
    output fetch_pkg::fet_bundle_t [fetch_width-1:0] fet_bundle,
    output logic [$clog2(fq_depth+1)-1:0]           fq_free
);
    import fetch_pkg::*;

    localparam int iw = $clog2(fq_depth);        // index width
    localparam int cw = $clog2(fq_depth + 1);    // count width
    localparam int aw = $clog2(fetch_width + 1);

    fet_bundle_t   mem [fq_depth];
    logic [iw-1:0] front;      // oldest entry
    logic [cw-1:0] count;      // entries held
    logic [aw-1:0] pop_num;    // slots consumed this cycle

    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            fet_bundle[i] = mem[front + iw'(i)];
            if (cw'(i) >= count) fet_bundle[i].valid = 1'b0;  // hide stale entries
        end
    end

    always_comb begin
        pop_num = '0;
        for (int i = 0; i < fetch_width; i++) begin
            if (fetch[i] && fet_bundle[i].valid) pop_num = pop_num + 1'b1;
        end
    end

    assign fq_free = cw'(fq_depth) - count;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            front <= '0;
            count <= '0;
        end else begin
            front <= front + iw'(pop_num);
            count <= count + cw'(accept_num) - cw'(pop_num);
        end
    end

    // tail writes, wrap relies on a power-of-two depth
    always_ff @(posedge clk) begin
        for (int i = 0; i < fetch_width; i++) begin
            if (aw'(i) < accept_num) mem[front + iw'(count) + iw'(i)] <= enq[i];
        end
    end

endmodule

/* rtl/fetch_frontend.sv */
// top level of the fetch frontend: takes fetch lines, delivers pre-decoded instruction slots
module fetch_frontend #(
    parameter int fetch_width    = fetch_pkg::FETCH_WIDTH,
    parameter int line_halfwords = fetch_pkg::LINE_HALFWORDS,
    parameter int fq_depth       = fetch_pkg::FQ_DEPTH
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  fetch_pkg::line_t                        line_in,
    input  logic                                    line_valid,
    output logic                                    line_ready,
    input  logic                                    flush,       // backend flush strobe
    input  logic [fetch_width-1:0]                  fetch,       // per-slot consume strobes
    output fetch_pkg::fet_bundle_t [fetch_width-1:0] fet_bundle,
    output fetch_pkg::redir_t                       redir
);
    import fetch_pkg::*;

    slot_t       [fetch_width-1:0]        slots;
    pd_info_t    [fetch_width-1:0]        pd;
    fet_bundle_t [fetch_width-1:0]        enq;
    logic [$clog2(fetch_width+1)-1:0]     accept_num;
    logic [$clog2(fq_depth+1)-1:0]        fq_free;
    logic                                 consume_all;  // drop rest of line on redirect

    line_splitter #(.fetch_width(fetch_width), .line_halfwords(line_halfwords))
        splitter_inst (
            .clk(clk), .rst(rst), .flush(flush),
            .line_in(line_in), .line_valid(line_valid), .line_ready(line_ready),
            .accept_num(accept_num), .consume_all(consume_all), .slots(slots)
        );

    predecoder #(.fetch_width(fetch_width))
        predecoder_inst (.slots(slots), .pd(pd));

    redirect_ctrl #(.fetch_width(fetch_width), .fq_depth(fq_depth))
        ctrl_inst (
            .slots(slots), .pd(pd), .fq_free(fq_free),
            .accept_num(accept_num), .consume_all(consume_all),
            .enq(enq), .redir(redir)
        );

    fetch_queue #(.fetch_width(fetch_width), .fq_depth(fq_depth))
        queue_inst (
            .clk(clk), .rst(rst), .flush(flush),
            .accept_num(accept_num), .enq(enq),
            .fetch(fetch), .fet_bundle(fet_bundle), .fq_free(fq_free)
        );

endmodule

/* testbench/fetch_frontend_sva.sv */
// concurrent checks on the fetch_frontend ports, attached to every fetch_frontend by bind
module fetch_frontend_sva #(
    parameter int fetch_width = 4
) (
    input logic                                     clk,
    input logic                                     rst,
    input logic                                     flush,
    input logic                                     line_valid,
    input logic                                     line_ready,
    input fetch_pkg::fet_bundle_t [fetch_width-1:0] fet_bundle,
    input fetch_pkg::redir_t                        redir
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [fetch_width-1:0] valid_bits;

    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            valid_bits[i] = fet_bundle[i].valid;
        end
    end

    redir_single: assert property (@(posedge clk) disable iff (rst) redir.valid |=> !redir.valid)
        else $error("redirect valid high for two cycles in a row");

    // ones from slot 0 upward, no holes
    valid_prefix: assert property (@(posedge clk) disable iff (rst)
        (valid_bits & (valid_bits + 1'b1)) == '0)
        else $error("output valid bits are not a prefix");

    ready_drops: assert property (@(posedge clk) disable iff (rst)
        line_valid && line_ready && !flush |=> !line_ready)
        else $error("line_ready still high after a line was taken");

endmodule

bind fetch_frontend fetch_frontend_sva #(.fetch_width(fetch_width)) sva_inst (
    .clk(clk), .rst(rst), .flush(flush), .line_valid(line_valid), .line_ready(line_ready),
    .fet_bundle(fet_bundle), .redir(redir)
);

/* testbench/tb_fetch_frontend.sv */
// testbench for fetch_frontend: sends lines, predicts slots and redirects, checks the output
module tb_fetch_frontend;
    timeunit 1ns;
    timeprecision 100ps;
    import fetch_pkg::*;

    localparam int num_lines  = 30;                      // lines sent over all tests
    localparam int max_cycles = num_lines * 20 + 200;

    logic                          clk, rst, line_valid, line_ready, flush, hold;
    line_t                         line_in, cur;
    logic [FETCH_WIDTH-1:0]        fetch;
    fet_bundle_t [FETCH_WIDTH-1:0] fet_bundle;
    redir_t                        redir;
    fet_bundle_t                   exp_q[$];
    redir_t                        exp_redir_q[$];
    int                            seed = 5942;
    int                            errors = 0, checks = 0, tests = 0, test_errors = 0;
    int                            cycles = 0;
    addr_t                         next_pc = 64'h8000_0000;

    fetch_frontend fetch_frontend_inst (
        .clk(clk), .rst(rst), .line_in(line_in), .line_valid(line_valid),
        .line_ready(line_ready), .flush(flush), .fetch(fetch),
        .fet_bundle(fet_bundle), .redir(redir)
    );

    function automatic addr_t sext(input logic [63:0] v, input int n);
        sext = v;
        for (int b = n; b < 64; b++) begin
            sext[b] = v[n-1];
        end
    endfunction

    function automatic logic is_link(input logic [4:0] r);
        return r == 5'd1 || r == 5'd5;                   // ra or t0
    endfunction

    // expected slots and redirect for one line, straight from the ISA encodings
    function automatic void predict_line(input line_t l);
        int          p;
        logic        wide;
        logic [31:0] w;
        logic [4:0]  rd, rs1;
        fet_bundle_t e;
        addr_t       tgt;
        redir_t      r;
        p = 0;
        while (p < int'(l.size)) begin
            wide = l.data[p][1:0] == 2'b11;
            w = wide ? {l.data[p+1], l.data[p]} : {16'h0, l.data[p]};
            e = '0;
            e.valid = 1'b1;
            e.pc = l.pc + addr_t'(2 * p);
            e.ir = w;
            tgt = e.pc + (wide ? 64'd4 : 64'd2);         // fall-through
            if (wide) begin
                rd = w[11:7];
                rs1 = w[19:15];
                e.branch = w[6:0] == 7'h63;
                e.jal = w[6:0] == 7'h6F;
                e.jalr = w[6:0] == 7'h67;
                if (e.branch) tgt = e.pc + sext({w[31], w[7], w[30:25], w[11:8], 1'b0}, 13);
                if (e.jal) tgt = e.pc + sext({w[31], w[19:12], w[20], w[30:21], 1'b0}, 21);
                e.call = (e.jal || e.jalr) && is_link(rd);
                e.ret = e.jalr && is_link(rs1) && rs1 != rd;
            end else if (w[1:0] == 2'b01 && w[15:13] == 3'b101) begin
                e.jal = 1'b1;                            // c.j
                tgt = e.pc + sext({w[12], w[8], w[10:9], w[6], w[7], w[2], w[11], w[5:3],
                    1'b0}, 12);
            end else if (w[1:0] == 2'b01 && w[15:14] == 2'b11) begin
                e.branch = 1'b1;                         // c.beqz, c.bnez
                tgt = e.pc + sext({w[12], w[6:5], w[2], w[11:10], w[4:3], 1'b0}, 9);
            end else if (w[1:0] == 2'b10 && w[15:13] == 3'b100 && w[6:2] == 5'd0) begin
                e.jalr = 1'b1;                           // c.jr, c.jalr
                e.call = w[12];
                e.ret = is_link(w[11:7]) && !(w[12] && w[11:7] == 5'd1);
            end
            exp_q.push_back(e);
            if (p + (wide ? 2 : 1) == int'(l.size)) begin
                r = '0;
                r.pc = e.pc + (wide ? 64'd2 : 64'd0);
                r.npc = tgt;
                if (l.pred_taken && !(e.branch || e.jal || e.jalr)) begin
                    r.valid = 1'b1;
                    r.pat = 2'b10;
                end else if ((e.jal && !l.pred_taken)
                    || ((e.jal || (e.branch && l.pred_taken)) && tgt[7:1] != l.pred_tgt)) begin
                    r.valid = 1'b1;
                    r.pat = 2'b01;
                end
                if (r.valid) exp_redir_q.push_back(r);
            end
            p = p + (wide ? 2 : 1);
        end
    endfunction

    task automatic check_field(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t %s got %h exp %h", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [31:0] plain_inst(input logic wide_inst);
        logic [31:0] r;
        r = $random(seed);
        return wide_inst ? {r[31:7], 7'b0010011} : {16'h0, 3'b000, r[12:2], 2'b01};  // addi
    endfunction

    task automatic start_line(input logic taken, input logic [6:0] tgt);
        cur = '0;
        cur.pc = next_pc;
        cur.pred_taken = taken;
        cur.pred_tgt = tgt;
        next_pc = next_pc + 64'd8;
    endtask

    task automatic put_inst(input logic [31:0] w);
        cur.data[cur.size] = w[15:0];
        if (w[1:0] == 2'b11) begin
            cur.data[cur.size + 3'd1] = w[31:16];
            cur.size = cur.size + 3'd2;
        end else begin
            cur.size = cur.size + 3'd1;
        end
    endtask

    // entered and left 1 ns after a rising edge
    task automatic send_line();
        predict_line(cur);
        line_in = cur;
        line_valid = 1'b1;
        @(negedge clk);
        while (!line_ready) @(negedge clk);
        @(posedge clk);
        #1;
        line_valid = 1'b0;
    endtask

    task automatic random_line(input logic taken);
        start_line(taken, 7'($random(seed)));
        while (cur.size < 3'(LINE_HALFWORDS)) begin
            put_inst(plain_inst(cur.size <= 3'(LINE_HALFWORDS - 2) && $random(seed) % 2 != 0));
        end
        send_line();
    endtask

    task automatic jal_line(input logic taken, input logic right);
        addr_t tgt;
        tgt = next_pc + 64'd20;                          // jal at byte 4, offset 16
        start_line(taken, right ? tgt[7:1] : ~tgt[7:1]);
        put_inst(plain_inst(1'b0));
        put_inst(plain_inst(1'b0));
        put_inst(32'h010000EF);                          // jal x1, +16
        send_line();
    endtask

    task automatic set_hold(input logic v);
        @(negedge clk);
        hold = v;
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input string name);
        while (exp_q.size() != 0) @(posedge clk);
        repeat (3) @(posedge clk);                       // room for a stray slot or redirect
        #1;
        if (exp_redir_q.size() != 0) begin
            $display("%0d expected redirects never appeared", exp_redir_q.size());
            errors++;
            exp_redir_q.delete();
        end
        $display("test %s finished with %0d errors", name, errors - test_errors);
        tests++;
        test_errors = errors;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin : consumer
        int k;
        fetch = '0;
        forever begin
            @(posedge clk);
            #1;
            k = {$random(seed)} % (FETCH_WIDTH + 1);
            fetch = hold ? '0 : FETCH_WIDTH'((1 << k) - 1);  // random prefix
        end
    end

    always @(negedge clk) begin : scoreboard
        fet_bundle_t e;
        redir_t      r;
        if (!rst) begin
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                if (fetch[i] && fet_bundle[i].valid) begin
                    if (exp_q.size() == 0) begin
                        $display("unexpected instruction at pc %h, time %0t", fet_bundle[i].pc,
                            $time);
                        errors++;
                    end else begin
                        e = exp_q.pop_front();
                        check_field($sformatf("fet_bundle[%0d].pc", i), fet_bundle[i].pc, e.pc);
                        check_field($sformatf("fet_bundle[%0d].ir", i), 64'(fet_bundle[i].ir),
                            64'(e.ir));
                        check_field($sformatf("fet_bundle[%0d].flags", i),
                            64'({fet_bundle[i].branch, fet_bundle[i].jal, fet_bundle[i].jalr,
                                 fet_bundle[i].call, fet_bundle[i].ret}),
                            64'({e.branch, e.jal, e.jalr, e.call, e.ret}));
                    end
                end
            end
            if (redir.valid) begin
                if (exp_redir_q.size() == 0) begin
                    $display("unexpected redirect to %h at time %0t", redir.npc, $time);
                    errors++;
                end else begin
                    r = exp_redir_q.pop_front();
                    check_field("redir.pc", redir.pc, r.pc);
                    check_field("redir.npc", redir.npc, r.npc);
                    check_field("redir.pat", 64'(redir.pat), 64'(r.pat));
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        int n_valid;
        rst = 1'b1;
        line_valid = 1'b0;
        line_in = '0;
        flush = 1'b0;
        hold = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        repeat (10) random_line(1'b0);
        finish_test("mixed widths");

        start_line(1'b0, 7'h0);
        put_inst(32'h010000EF);                          // jal x1, +16
        put_inst(32'h00008067);                          // jalr x0, 0(x1)
        send_line();
        start_line(1'b0, 7'h0);
        put_inst(32'h000282E7);                          // jalr x5, 0(x5)
        put_inst(32'h000280E7);                          // jalr x1, 0(x5)
        send_line();
        start_line(1'b0, 7'h0);
        put_inst(32'hFE000CE3);                          // beq x0, x0, -8
        put_inst(32'h0000A019);                          // c.j +6
        put_inst(32'h0000C011);                          // c.beqz x8, +4
        send_line();
        start_line(1'b0, 7'h0);
        put_inst(32'h00009282);                          // c.jalr x5
        put_inst(32'h00008082);                          // c.jr x1
        put_inst(plain_inst(1'b1));
        send_line();
        finish_test("classification");

        repeat (2) random_line(1'b1);
        finish_test("false taken");

        jal_line(1'b0, 1'b0);
        jal_line(1'b1, 1'b0);
        jal_line(1'b1, 1'b1);
        finish_test("jal target");

        // four full lines fill the queue, the fifth waits in the buffer
        set_hold(1'b1);
        repeat (5) begin
            start_line(1'b0, 7'h0);
            repeat (4) put_inst(plain_inst(1'b0));
            send_line();
        end
        repeat (6) begin
            @(negedge clk);
            if (line_ready) begin
                $display("line_ready high at %0t while the queue is full", $time);
                errors++;
            end
        end
        set_hold(1'b0);
        repeat (2) random_line(1'b0);
        finish_test("back-pressure");

        // first line sits in the queue, second one still in the buffer
        set_hold(1'b1);
        repeat (2) random_line(1'b0);
        flush = 1'b1;
        exp_q.delete();
        exp_redir_q.delete();
        @(posedge clk);
        #1;
        flush = 1'b0;
        @(negedge clk);
        n_valid = 0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (fet_bundle[i].valid) n_valid++;
        end
        if (n_valid != 0 || !line_ready) begin
            $display("outputs not cleared after flush at %0t", $time);
            errors++;
        end
        set_hold(1'b0);
        repeat (2) random_line(1'b0);
        finish_test("flush");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* fetch_frontend.f */
rtl/fetch_pkg.sv
rtl/line_splitter.sv
rtl/predecoder.sv
rtl/redirect_ctrl.sv
rtl/fetch_queue.sv
rtl/fetch_frontend.sv
testbench/fetch_frontend_sva.sv
testbench/tb_fetch_frontend.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fetch_frontend testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch_frontend \
    -f fetch_frontend.f -o sim_fetch_frontend
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_fetch_frontend > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
    exit 0
fi
exit 1
